//--- Bender.yml
package:
  name: ing_adapt

sources:
  - include_dirs:
      - .
    files:
      - ing_adapt_pkg.sv
      - ing_port_gate.sv
      - ing_port_profile.sv
      - ing_frame_fifo.sv
      - ing_port_array_adapt.sv
  - target: test
    include_dirs:
      - .
    files:
      - ing_adapt_asserts.sv
      - ing_adapt_tb.sv

//--- ing_adapt.f
+incdir+.
ing_adapt_pkg.sv
ing_port_gate.sv
ing_port_profile.sv
ing_frame_fifo.sv
ing_port_array_adapt.sv
ing_adapt_asserts.sv
ing_adapt_tb.sv

//--- ing_adapt_asserts.sv
////////////////////////////////////////
// Ingress adapter stream assertions
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ing_adapt_consts.svh"

module ing_adapt_asserts (
    input var logic                                           clk,
    input var logic                                           rst_n,
    input var logic [`ING_NUM_PORTS-1:0]                      out_valid,
    input var ing_adapt_pkg::axis_beat_t [`ING_NUM_PORTS-1:0] out_beat,
    input var logic [`ING_NUM_PORTS-1:0]                      out_ready,
    input var logic [`ING_NUM_PORTS-1:0]                      ports_connected,
    input var logic [`ING_NUM_PORTS-1:0]                      buf_overflow
);

    int fails = 0;

    // No port connects while reset is held
    reset_idle_a: assert property (@(negedge clk) !rst_n |-> ports_connected == '0)
        else begin
            $error("ports_connected high during reset");
            fails++;
        end

    for (genvar p = 0; p < `ING_NUM_PORTS; p++) begin : port_g
        // Stalled output keeps its beat
        out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_beat[p]))
            else begin
                $error("port %0d output beat changed while stalled", p);
                fails++;
            end

        ovf_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
            buf_overflow[p] |=> !buf_overflow[p])
            else begin
                $error("port %0d overflow high for two cycles", p);
                fails++;
            end
    end

endmodule

`default_nettype wire

//--- ing_adapt_consts.svh
////////////////////////////////////////
// Ingress adapter constants
// Port count, beat width, FIFO depth and counter width
////////////////////////////////////////

`ifndef ING_ADAPT_CONSTS_SVH
`define ING_ADAPT_CONSTS_SVH

// Physical ingress ports on the adapter
`define ING_NUM_PORTS 2

// Bytes per stream beat, shared by the physical ports and the converged bus
`define ING_DATA_BYTES 4

// Words per frame FIFO, sized for two short frames
`define ING_FIFO_DEPTH 16

// Width of every profile counter
`define ING_CNT_WIDTH 32

`endif

//--- ing_adapt_pkg.sv
////////////////////////////////////////
// Ingress adapter types
////////////////////////////////////////

`default_nettype none

`include "ing_adapt_consts.svh"

package ing_adapt_pkg;

    // One stream beat, tuser tags a bad frame on the last beat
    typedef struct packed {
        logic [`ING_DATA_BYTES*8-1:0] tdata;
        logic [`ING_DATA_BYTES-1:0]   tkeep;
        logic                         tlast;
        logic                         tuser;
    } axis_beat_t;

    // Per-port traffic profile
    typedef struct packed {
        logic [`ING_CNT_WIDTH-1:0] frames;
        logic [`ING_CNT_WIDTH-1:0] bytes;
        logic [`ING_CNT_WIDTH-1:0] errors;
        logic [`ING_CNT_WIDTH-1:0] drops;
    } ing_counts_t;

    typedef enum logic [1:0] {GATE_IDLE, GATE_PASS, GATE_DROP} gate_state_e;

    typedef enum logic {WR_ACCEPT, WR_DISCARD} fifo_wr_state_e;

endpackage

`default_nettype wire

//--- ing_adapt_tb.sv
////////////////////////////////////////
// Ingress adapter testbench
// Table-driven frames checked against a reference model
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ing_adapt_consts.svh"

module ing_adapt_tb;

    localparam int NP = `ING_NUM_PORTS;
    localparam int NT = 6;

    // Port, frame count, beats per frame, last keep, bad flag, enable and output hold
    typedef struct packed {
        logic [7:0]                 port;
        logic [7:0]                 frames;
        logic [7:0]                 len;
        logic [`ING_DATA_BYTES-1:0] last_keep;
        logic                       bad;
        logic                       enable;
        logic                       hold;
    } test_row_t;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic [NP-1:0]                       in_valid;
    logic [NP-1:0]                       in_ready;
    logic [NP-1:0]                       out_valid;
    logic [NP-1:0]                       out_ready;
    logic [NP-1:0]                       ports_enable;
    logic [NP-1:0]                       cnts_clear;
    logic [NP-1:0]                       ports_connected;
    logic [NP-1:0]                       buf_overflow;
    ing_adapt_pkg::axis_beat_t [NP-1:0]  in_beat;
    ing_adapt_pkg::axis_beat_t [NP-1:0]  out_beat;
    ing_adapt_pkg::ing_counts_t [NP-1:0] cnts;

    // Reference model state
    ing_adapt_pkg::ing_counts_t exp_cnts [NP];
    ing_adapt_pkg::axis_beat_t  exp_q [$];
    ing_adapt_pkg::axis_beat_t  got_q [$];
    test_row_t rows [NT];
    string     names [NT];
    int        cur_port;
    int        errs;
    int        n_pass;
    int        n_fail;
    logic      saw_ovf;
    logic      saw_stall;

    always #5 clk = ~clk;

    ing_port_array_adapt u_dut (.*);

    bind ing_port_array_adapt ing_adapt_asserts u_asserts (.*);

    // Collect output beats and overflow pulses of the port under test
    always @(negedge clk) begin
        if (rst_n && out_valid[cur_port] && out_ready[cur_port]) begin
            got_q.push_back(out_beat[cur_port]);
        end
        if (buf_overflow[cur_port]) begin
            saw_ovf = 1'b1;
        end
    end

    task automatic drive_beat(input int p, input ing_adapt_pkg::axis_beat_t b);
        in_valid[p] = 1'b1;
        in_beat[p]  = b;
        do begin
            @(negedge clk);
            if (!in_ready[p]) begin
                saw_stall = 1'b1;
            end
        end while (!in_ready[p]);
        @(posedge clk);
        #1;
    endtask

    task automatic check_beat(input string name, input ing_adapt_pkg::axis_beat_t exp, act);
        if (exp !== act) begin
            errs++;
            $display("[FAIL] %s: beat expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_counts(input string name, input ing_adapt_pkg::ing_counts_t exp, act);
        if (exp !== act) begin
            errs++;
            $display("[FAIL] %s: counts expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp, act);
        if (exp !== act) begin
            errs++;
            $display("[FAIL] %s: %s expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: %s", name, (errs == 0) ? "ok" : "errors");
        n_pass += (errs == 0);
        n_fail += (errs != 0);
        errs = 0;
    endtask

    initial begin
        int total;
        int stored;
        logic exp_ovf;
        logic fits;
        ing_adapt_pkg::axis_beat_t b;
        test_row_t r;

        void'($urandom(32'hc46a6fa5));
        in_valid     = '0;
        in_beat      = '0;
        out_ready    = '1;
        ports_enable = '0;
        cnts_clear   = '0;
        foreach (exp_cnts[p]) begin
            exp_cnts[p] = '0;
        end
        names = '{"pass_p0", "pass_p1", "count_p0", "count_p1", "disable_p1", "overflow_p0"};
        rows[0] = {8'd0, 8'd3, 8'd4, 4'hf, 1'b0, 1'b1, 1'b0};
        rows[1] = {8'd1, 8'd3, 8'd5, 4'hf, 1'b0, 1'b1, 1'b0};
        rows[2] = {8'd0, 8'd4, 8'd3, 4'h3, 1'b1, 1'b1, 1'b0};
        rows[3] = {8'd1, 8'd3, 8'd2, 4'h1, 1'b1, 1'b1, 1'b0};
        rows[4] = {8'd1, 8'd2, 8'd4, 4'hf, 1'b0, 1'b0, 1'b0};
        rows[5] = {8'd0, 8'd3, 8'd6, 4'hf, 1'b0, 1'b1, 1'b1};
        total = 0;
        foreach (rows[t]) begin
            total += rows[t].frames * rows[t].len;
        end
        fork
            begin
                repeat (total * 20 + 1000) @(posedge clk);
                $display("Watchdog expired before the tests finished");
                $display("FAIL: see errors above");
                $finish;
            end
        join_none

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (rows[t]) begin
            r = rows[t];
            exp_q.delete();
            got_q.delete();
            stored  = 0;
            exp_ovf = 1'b0;
            @(posedge clk);
            #1;
            cur_port  = r.port;
            saw_ovf   = 1'b0;
            saw_stall = 1'b0;
            ports_enable[r.port] = r.enable;
            out_ready[r.port]    = !r.hold;
            for (int f = 0; f < r.frames; f++) begin
                // A frame reaches the output only if enabled and small enough for the FIFO
                fits = r.enable && (!r.hold || stored + r.len <= `ING_FIFO_DEPTH);
                exp_ovf |= r.enable && !fits;
                stored += fits ? r.len : 0;
                for (int k = 0; k < r.len; k++) begin
                    b.tdata = $urandom;
                    b.tlast = (k == r.len - 1);
                    b.tkeep = b.tlast ? r.last_keep : '1;
                    b.tuser = b.tlast && r.bad && (f % 2 == 0);
                    if (fits) begin
                        exp_q.push_back(b);
                    end
                    drive_beat(r.port, b);
                end
                if (r.enable) begin
                    exp_cnts[r.port].frames += 1;
                    exp_cnts[r.port].bytes  +=
                        (r.len - 1) * `ING_DATA_BYTES + $countones(r.last_keep);
                    exp_cnts[r.port].errors += (r.bad && f % 2 == 0);
                end else begin
                    exp_cnts[r.port].drops += 1;
                end
            end
            in_valid[r.port]  = 1'b0;
            out_ready[r.port] = 1'b1;
            // Done once the port's FIFO has emptied
            do @(negedge clk); while (out_valid[r.port]);
            if (got_q.size() != exp_q.size()) begin
                errs++;
                $display("[FAIL] %s: output beats expected %0d actual %0d",
                         names[t], exp_q.size(), got_q.size());
            end else begin
                foreach (exp_q[i]) begin
                    check_beat(names[t], exp_q[i], got_q[i]);
                end
            end
            check_counts(names[t], exp_cnts[r.port], cnts[r.port]);
            check_flag(names[t], "connected", r.enable, ports_connected[r.port]);
            check_flag(names[t], "overflow", exp_ovf, saw_ovf);
            check_flag(names[t], "input stall", 1'b0, saw_stall);
            report_test(names[t]);
        end

        // Clear port 0 only
        @(posedge clk);
        #1;
        cnts_clear[0] = 1'b1;
        @(posedge clk);
        #1;
        cnts_clear[0] = 1'b0;
        exp_cnts[0]   = '0;
        @(negedge clk);
        for (int p = 0; p < NP; p++) begin
            check_counts("clear_p0", exp_cnts[p], cnts[p]);
        end
        report_test("clear_p0");

        $display("tests passed %0d failed %0d, assertion failures %0d",
                 n_pass, n_fail, u_dut.u_asserts.fails);
        if (n_fail == 0 && u_dut.u_asserts.fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ing_frame_fifo.sv
////////////////////////////////////////
// Store-and-forward frame FIFO
// Drops frames that do not fit and flags overflow
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ing_adapt_consts.svh"

module ing_frame_fifo (
    input  var logic                       clk,
    input  var logic                       rst_n,
    input  var logic                       in_valid,
    input  var ing_adapt_pkg::axis_beat_t  in_beat,
    output var logic                       in_ready,
    output var logic                       out_valid,
    output var ing_adapt_pkg::axis_beat_t  out_beat,
    input  var logic                       out_ready,
    output var logic                       overflow
);

    localparam int AW = $clog2(`ING_FIFO_DEPTH);
    localparam logic [AW:0] DEPTH = `ING_FIFO_DEPTH;

    ing_adapt_pkg::axis_beat_t mem [`ING_FIFO_DEPTH];

    // Pointers carry one wrap bit above the address
    logic [AW:0] wr_ptr;
    logic [AW:0] commit_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] wr_level;
    logic        fifo_full;
    logic        do_write;

    ing_adapt_pkg::fifo_wr_state_e wr_state;

    // Feed-forward path, beats never wait at the input
    assign in_ready = 1'b1;

    // Level includes beats of the frame still being written
    assign wr_level  = wr_ptr - rd_ptr;
    assign fifo_full = (wr_level == DEPTH);
    assign do_write  = in_valid && (wr_state == ing_adapt_pkg::WR_ACCEPT) && !fifo_full;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= in_beat;
        end
    end

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state   <= ing_adapt_pkg::WR_ACCEPT;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            overflow   <= 1'b0;
        end else begin
            overflow <= 1'b0;
            case (wr_state)
                ing_adapt_pkg::WR_ACCEPT: begin
                    if (in_valid && fifo_full) begin
                        // Frame does not fit, forget what was written of it
                        wr_ptr <= commit_ptr;
                        if (in_beat.tlast) begin
                            overflow <= 1'b1;
                        end else begin
                            wr_state <= ing_adapt_pkg::WR_DISCARD;
                        end
                    end else if (in_valid) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        if (in_beat.tlast) begin
                            commit_ptr <= wr_ptr + 1'b1;
                        end
                    end
                end
                ing_adapt_pkg::WR_DISCARD: begin
                    if (in_valid && in_beat.tlast) begin
                        overflow <= 1'b1;
                        wr_state <= ing_adapt_pkg::WR_ACCEPT;
                    end
                end
                default: wr_state <= ing_adapt_pkg::WR_ACCEPT;
            endcase
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    // Only committed frames are visible
    assign out_valid = (rd_ptr != commit_ptr);
    assign out_beat  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (out_valid && out_ready) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- ing_port_array_adapt.sv
////////////////////////////////////////
// Ingress port array adapter
// Gate, profile and frame FIFO per port
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ing_adapt_consts.svh"

module ing_port_array_adapt (
    input  var logic                                             clk,
    input  var logic                                             rst_n,
    input  var logic [`ING_NUM_PORTS-1:0]                        in_valid,
    input  var ing_adapt_pkg::axis_beat_t [`ING_NUM_PORTS-1:0]   in_beat,
    output var logic [`ING_NUM_PORTS-1:0]                        in_ready,
    output var logic [`ING_NUM_PORTS-1:0]                        out_valid,
    output var ing_adapt_pkg::axis_beat_t [`ING_NUM_PORTS-1:0]   out_beat,
    input  var logic [`ING_NUM_PORTS-1:0]                        out_ready,
    input  var logic [`ING_NUM_PORTS-1:0]                        ports_enable,
    input  var logic [`ING_NUM_PORTS-1:0]                        cnts_clear,
    output var ing_adapt_pkg::ing_counts_t [`ING_NUM_PORTS-1:0]  cnts,
    output var logic [`ING_NUM_PORTS-1:0]                        ports_connected,
    output var logic [`ING_NUM_PORTS-1:0]                        buf_overflow
);

    for (genvar p = 0; p < `ING_NUM_PORTS; p++) begin : port_g

        // Link between gate and frame FIFO
        logic                      gated_valid;
        ing_adapt_pkg::axis_beat_t gated_beat;
        logic                      gated_ready;
        logic                      frame_dropped;

        ing_port_gate u_gate (
            .clk           (clk),
            .rst_n         (rst_n),
            .enable        (ports_enable[p]),
            .in_valid      (in_valid[p]),
            .in_beat       (in_beat[p]),
            .in_ready      (in_ready[p]),
            .out_valid     (gated_valid),
            .out_beat      (gated_beat),
            .out_ready     (gated_ready),
            .connected     (ports_connected[p]),
            .frame_dropped (frame_dropped)
        );

        // Profile watches the raw input link
        ing_port_profile u_profile (
            .clk           (clk),
            .rst_n         (rst_n),
            .enable        (ports_enable[p]),
            .clear         (cnts_clear[p]),
            .mon_valid     (in_valid[p]),
            .mon_ready     (in_ready[p]),
            .mon_beat      (in_beat[p]),
            .frame_dropped (frame_dropped),
            .counts        (cnts[p])
        );

        ing_frame_fifo u_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (gated_valid),
            .in_beat   (gated_beat),
            .in_ready  (gated_ready),
            .out_valid (out_valid[p]),
            .out_beat  (out_beat[p]),
            .out_ready (out_ready[p]),
            .overflow  (buf_overflow[p])
        );

    end

endmodule

`default_nettype wire

//--- ing_port_gate.sv
////////////////////////////////////////
// Ingress port gate
// Passes or discards whole frames by the port enable
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ing_port_gate (
    input  var logic                       clk,
    input  var logic                       rst_n,
    input  var logic                       enable,
    input  var logic                       in_valid,
    input  var ing_adapt_pkg::axis_beat_t  in_beat,
    output var logic                       in_ready,
    output var logic                       out_valid,
    output var ing_adapt_pkg::axis_beat_t  out_beat,
    input  var logic                       out_ready,
    output var logic                       connected,
    output var logic                       frame_dropped
);

    ing_adapt_pkg::gate_state_e state;
    ing_adapt_pkg::gate_state_e state_next;
    logic frame_start;
    logic pass_beat;
    logic beat_fire;

    // Idle means the next accepted beat opens a frame
    assign frame_start = (state == ing_adapt_pkg::GATE_IDLE);
    assign pass_beat   = (state == ing_adapt_pkg::GATE_PASS) || (frame_start && enable);

    ////////////////////////////////////////
    // Data path
    ////////////////////////////////////////

    assign out_valid = in_valid && pass_beat;
    assign out_beat  = in_beat;
    // Discarded beats are swallowed at full rate
    assign in_ready  = pass_beat ? out_ready : 1'b1;
    assign beat_fire = in_valid && in_ready;

    assign frame_dropped = beat_fire && !pass_beat && in_beat.tlast;

    ////////////////////////////////////////
    // Frame state
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        if (beat_fire) begin
            if (in_beat.tlast) begin
                state_next = ing_adapt_pkg::GATE_IDLE;
            end else if (frame_start) begin
                if (enable) begin
                    state_next = ing_adapt_pkg::GATE_PASS;
                end else begin
                    state_next = ing_adapt_pkg::GATE_DROP;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ing_adapt_pkg::GATE_IDLE;
            connected <= 1'b0;
        end else begin
            state <= state_next;
            // Latch the decision taken on each frame's first beat
            if (beat_fire && frame_start) begin
                connected <= enable;
            end
        end
    end

endmodule

`default_nettype wire

//--- ing_port_profile.sv
////////////////////////////////////////
// Ingress port profile
// Frame, byte, error and drop counters
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ing_adapt_consts.svh"

module ing_port_profile (
    input  var logic                       clk,
    input  var logic                       rst_n,
    input  var logic                       enable,
    input  var logic                       clear,
    input  var logic                       mon_valid,
    input  var logic                       mon_ready,
    input  var ing_adapt_pkg::axis_beat_t  mon_beat,
    input  var logic                       frame_dropped,
    output var ing_adapt_pkg::ing_counts_t counts
);

    logic                      mon_fire;
    logic                      count_beat;
    logic [`ING_CNT_WIDTH-1:0] keep_bytes;

    assign mon_fire   = mon_valid && mon_ready;
    assign count_beat = mon_fire && enable;

    // Population count of tkeep gives the bytes in this beat
    always_comb begin
        keep_bytes = '0;
        for (int i = 0; i < `ING_DATA_BYTES; i++) begin
            keep_bytes = keep_bytes + mon_beat.tkeep[i];
        end
    end

    ////////////////////////////////////////
    // Counters
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counts <= '0;
        end else if (clear) begin
            counts <= '0;
        end else begin
            if (count_beat) begin
                counts.bytes <= counts.bytes + keep_bytes;
                if (mon_beat.tlast) begin
                    counts.frames <= counts.frames + 1'b1;
                end
                if (mon_beat.tlast && mon_beat.tuser) begin
                    counts.errors <= counts.errors + 1'b1;
                end
            end
            // Drops happen only while disabled, so enable is not checked
            if (frame_dropped) begin
                counts.drops <= counts.drops + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
